// ==== common/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// rv32 datapath and address width
`define CPU_WIDTH      32
`define RESET_PC       32'h8000_0000

// single-port word memory
`define MEM_WORDS      256
`define MEM_INDEX_BITS 8  // word index from addr[9:2]

`endif

// ==== common/core_types_pkg.sv ====
`include "rv_settings.svh"

package core_types_pkg;

    typedef logic [`CPU_WIDTH-1:0] addr_t;  // byte address
    typedef logic [`CPU_WIDTH-1:0] word_t;  // instruction or data word

    // external mul/div progress seen by the core
    typedef enum logic [1:0] {
        MD_IDLE   = 2'd0,
        MD_BUSY   = 2'd1,
        MD_RESULT = 2'd2
    } md_status_t;

    // pc_gen mul/div tracking states
    typedef enum logic [1:0] {
        S_IDLE, S_ARITH, S_FINISH, S_TAIL
    } md_state_t;

endpackage

// ==== common/bus_types_pkg.sv ====
`include "rv_settings.svh"

package bus_types_pkg;

    typedef logic [`MEM_INDEX_BITS-1:0] mem_index_t;  // word index into memory

    // who holds the memory grant
    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_LSU   = 1'b1
    } req_id_t;

endpackage

// ==== common/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
    import core_types_pkg::*;

    logic  req;    // level, held until done
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;  // valid with done
    logic  done;   // single-cycle pulse

    modport master (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

// ==== fetch/pc_gen.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       redirect,
    input  core_types_pkg::addr_t      redirect_pc,
    input  logic                       jalr,
    input  core_types_pkg::addr_t      jalr_pc,
    input  logic                       mem_stall,
    input  logic                       md_start,
    input  logic                       md_is_div,
    input  logic                       md_finish,
    input  logic                       fetch_done,
    output core_types_pkg::addr_t      pc,
    output logic                       fetch_en,
    output logic                       fetch_hold,
    output core_types_pkg::md_status_t md_status
);
    import core_types_pkg::*;

    logic      jalr_d;
    logic      mul_wait;
    logic      div_wait;
    md_state_t state;
    md_state_t state_nxt;

    assign mul_wait = md_start && !md_is_div && !md_finish;
    assign div_wait = md_start && md_is_div && !md_finish;

    // no new fetch while held or while a new target lands
    assign fetch_hold = mul_wait || div_wait || mem_stall || jalr || jalr_d || redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
            jalr_d   <= 1'b0;
        end else begin
            fetch_en <= 1'b1;  // one cycle after reset
            jalr_d   <= jalr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (mul_wait || div_wait || mem_stall) begin
            // a fetch already on the bus still retires
            if (fetch_done) begin
                pc <= pc + addr_t'(4);
            end
        end else if (jalr) begin
            pc <= pc;  // target arrives next cycle
        end else if (jalr_d) begin
            pc <= jalr_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (fetch_done) begin
            pc <= pc + addr_t'(4);
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (md_start) state_nxt = S_ARITH;
            S_ARITH:  if (md_finish) state_nxt = S_FINISH;
            S_FINISH: state_nxt = fetch_done ? S_TAIL : S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            md_status <= MD_IDLE;
        end else begin
            state <= state_nxt;
            case (state)  // status lags the fsm by one cycle
                S_ARITH, S_FINISH: md_status <= MD_BUSY;
                S_TAIL:            md_status <= MD_RESULT;
                default:           md_status <= MD_IDLE;
            endcase
        end
    end

    a_ctrl_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect && jalr) && (pc[1:0] == 2'b00));

endmodule

// ==== fetch/ifetch.sv ====
`timescale 1ns/1ps

module ifetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_types_pkg::addr_t pc,
    input  logic                  fetch_en,
    input  logic                  fetch_hold,
    input  logic                  redirect,
    mem_bus_if.master             bus,
    output core_types_pkg::word_t instr,
    output core_types_pkg::addr_t instr_pc,
    output logic                  instr_valid,
    output logic                  fetch_done
);
    import core_types_pkg::*;

    logic  busy;      // read outstanding
    logic  stale;     // outstanding read was flushed
    logic  issue;
    logic  deliver;
    addr_t req_addr;

    assign issue   = !busy && fetch_en && !fetch_hold;
    assign deliver = bus.done && !stale && !redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            stale <= 1'b0;
        end else if (bus.done) begin
            busy  <= 1'b0;
            stale <= 1'b0;
        end else if (busy) begin
            if (redirect) stale <= 1'b1;
        end else if (issue) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) req_addr <= pc;
    end

    assign bus.req   = busy;
    assign bus.we    = 1'b0;  // reads only
    assign bus.addr  = req_addr;
    assign bus.wdata = '0;

    assign instr       = bus.rdata;
    assign instr_pc    = req_addr;
    assign instr_valid = deliver;
    assign fetch_done  = deliver;

    // delivered fetch still matches the pc it advances
    a_pc_match: assert property (@(posedge clk) disable iff (!rst_n)
        deliver |-> (req_addr == pc));

endmodule

// ==== source/lsu_port.sv ====
`timescale 1ns/1ps

module lsu_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lsu_req,
    input  logic                  lsu_we,
    input  core_types_pkg::addr_t lsu_addr,
    input  core_types_pkg::word_t lsu_wdata,
    mem_bus_if.master             bus,
    output core_types_pkg::word_t lsu_rdata,
    output logic                  lsu_done,
    output logic                  mem_stall
);
    import core_types_pkg::*;

    logic  pend;
    logic  capture;
    logic  we_q;
    addr_t addr_q;
    word_t wdata_q;

    assign capture = lsu_req && !pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else if (bus.done) begin
            pend <= 1'b0;
        end else if (capture) begin
            pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            we_q    <= lsu_we;
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
        end
    end

    // strobe cycle goes straight to the bus, latched copy holds it after
    assign bus.req   = pend || lsu_req;
    assign bus.we    = pend ? we_q : lsu_we;
    assign bus.addr  = pend ? addr_q : lsu_addr;
    assign bus.wdata = pend ? wdata_q : lsu_wdata;

    assign lsu_rdata = bus.rdata;
    assign lsu_done  = bus.done;
    assign mem_stall = pend;

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        pend |-> !lsu_req);

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic      clk,
    input  logic      rst_n,
    mem_bus_if.slave  fetch_bus,
    mem_bus_if.slave  lsu_bus,
    mem_bus_if.master mem_bus
);
    import bus_types_pkg::*;

    logic    busy;     // grant held until done
    logic    any_req;
    req_id_t owner;
    req_id_t sel;

    assign any_req = fetch_bus.req || lsu_bus.req;

    // lsu wins a tie, an active grant is never broken
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (lsu_bus.req) begin
            sel = REQ_LSU;
        end else begin
            sel = REQ_FETCH;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= REQ_FETCH;
        end else if (mem_bus.done) begin
            busy <= 1'b0;
        end else if (!busy && any_req) begin
            busy  <= 1'b1;
            owner <= sel;
        end
    end

    assign mem_bus.req   = (sel == REQ_LSU) ? lsu_bus.req   : fetch_bus.req;
    assign mem_bus.we    = (sel == REQ_LSU) ? lsu_bus.we    : fetch_bus.we;
    assign mem_bus.addr  = (sel == REQ_LSU) ? lsu_bus.addr  : fetch_bus.addr;
    assign mem_bus.wdata = (sel == REQ_LSU) ? lsu_bus.wdata : fetch_bus.wdata;

    // response only reaches the owner
    assign fetch_bus.done  = mem_bus.done && (owner == REQ_FETCH);
    assign lsu_bus.done    = mem_bus.done && (owner == REQ_LSU);
    assign fetch_bus.rdata = (owner == REQ_FETCH) ? mem_bus.rdata : '0;
    assign lsu_bus.rdata   = (owner == REQ_LSU) ? mem_bus.rdata : '0;

    a_done_granted: assert property (@(posedge clk) disable iff (!rst_n)
        mem_bus.done |-> busy);

endmodule

// ==== source/sram_port.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module sram_port (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);
    import core_types_pkg::*;
    import bus_types_pkg::*;

    word_t      mem [0:`MEM_WORDS-1];
    word_t      rdata_q;
    mem_index_t idx;
    logic       accept;
    logic       done_q;

    assign idx    = bus.addr[`MEM_INDEX_BITS+1:2];
    assign accept = bus.req && !done_q;  // req still high during done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (bus.we) begin
                mem[idx] <= bus.wdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       redirect,
    input  core_types_pkg::addr_t      redirect_pc,
    input  logic                       jalr,
    input  core_types_pkg::addr_t      jalr_pc,
    input  logic                       md_start,
    input  logic                       md_is_div,
    input  logic                       md_finish,
    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  core_types_pkg::addr_t      lsu_addr,
    input  core_types_pkg::word_t      lsu_wdata,
    output core_types_pkg::addr_t      pc,
    output core_types_pkg::word_t      instr,
    output core_types_pkg::addr_t      instr_pc,
    output logic                       instr_valid,
    output core_types_pkg::md_status_t md_status,
    output core_types_pkg::word_t      lsu_rdata,
    output logic                       lsu_done
);
    logic fetch_en;
    logic fetch_hold;
    logic fetch_done;
    logic mem_stall;
    logic flush;

    mem_bus_if fetch_bus ();
    mem_bus_if lsu_bus ();
    mem_bus_if mem_bus ();

    assign flush = redirect || jalr;  // jalr also drops the read in flight

    pc_gen u_pc_gen (
        .clk(clk), .rst_n(rst_n),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .jalr(jalr), .jalr_pc(jalr_pc), .mem_stall(mem_stall),
        .md_start(md_start), .md_is_div(md_is_div), .md_finish(md_finish),
        .fetch_done(fetch_done), .pc(pc), .fetch_en(fetch_en),
        .fetch_hold(fetch_hold), .md_status(md_status)
    );

    ifetch u_ifetch (
        .clk(clk), .rst_n(rst_n), .pc(pc), .fetch_en(fetch_en),
        .fetch_hold(fetch_hold), .redirect(flush), .bus(fetch_bus),
        .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
        .fetch_done(fetch_done)
    );

    lsu_port u_lsu_port (
        .clk(clk), .rst_n(rst_n), .lsu_req(lsu_req), .lsu_we(lsu_we),
        .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata), .bus(lsu_bus),
        .lsu_rdata(lsu_rdata), .lsu_done(lsu_done), .mem_stall(mem_stall)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .rst_n(rst_n),
        .fetch_bus(fetch_bus), .lsu_bus(lsu_bus), .mem_bus(mem_bus)
    );

    sram_port u_sram_port (
        .clk(clk), .rst_n(rst_n), .bus(mem_bus)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;  // released just after the 4th rising edge
    end

    always #2 clk = ~clk;  // 4 ns period

endmodule

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_fetch_top;
    import core_types_pkg::*;

    localparam int    N_STORE = 32;
    localparam int    N_RUN   = 32;  // fetches watched after the first redirect
    localparam int    N_MIX   = 24;
    localparam int    BUS_OPS = 2 * N_STORE + N_RUN + 4 + 4 + N_MIX + 4;
    localparam int    LIMIT   = 20 * BUS_OPS + 200;
    localparam addr_t BASE    = `RESET_PC + 32'h100;  // start of written region

    logic       clk;
    logic       rst_n;
    logic       redirect;
    addr_t      redirect_pc;
    logic       jalr;
    addr_t      jalr_pc;
    logic       md_start;
    logic       md_is_div;
    logic       md_finish;
    logic       lsu_req;
    logic       lsu_we;
    addr_t      lsu_addr;
    word_t      lsu_wdata;
    addr_t      pc;
    word_t      instr;
    addr_t      instr_pc;
    logic       instr_valid;
    md_status_t md_status;
    word_t      lsu_rdata;
    logic       lsu_done;

    // reference model state
    word_t       shadow [0:`MEM_WORDS-1];
    logic        known  [0:`MEM_WORDS-1];  // word written at least once
    addr_t       model_pc;
    logic        track  = 1'b0;
    logic [31:0] lfsr   = 32'h6ed9;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    int          cycles = 0;

    tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    fetch_top dut0 (.*);

    // fibonacci lfsr, taps 32/22/2/1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t expected_instr(input addr_t a);
        return shadow[a[`MEM_INDEX_BITS+1:2]];
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input md_status_t got,
                                input md_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic test_done(input int num, input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - e0);
        end
    endtask

    // one strobe, then wait for lsu_done
    task automatic lsu_access(input logic we, input addr_t a, input word_t d,
                              output word_t q);
        @(posedge clk);
        #1;
        lsu_req   = 1'b1;
        lsu_we    = we;
        lsu_addr  = a;
        lsu_wdata = d;
        @(posedge clk);
        #1;
        lsu_req = 1'b0;
        @(negedge clk);
        while (!lsu_done) @(negedge clk);
        q = lsu_rdata;
        if (we) begin
            shadow[a[`MEM_INDEX_BITS+1:2]] = d;
            known[a[`MEM_INDEX_BITS+1:2]]  = 1'b1;
        end
    endtask

    task automatic redirect_to(input addr_t t);
        @(posedge clk);
        #1;
        redirect    = 1'b1;
        redirect_pc = t;
        model_pc    = t;
        track       = 1'b1;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic jalr_to(input addr_t t);
        @(posedge clk);
        #1;
        jalr     = 1'b1;
        jalr_pc  = t;  // stays put for the cycle after the pulse
        model_pc = t;
        @(posedge clk);
        #1;
        jalr = 1'b0;
    endtask

    task automatic wait_instr(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (instr_valid) seen++;
        end
    endtask

    // compare every delivered instruction with the model
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && track && instr_valid) begin
                check_addr("instr_pc", instr_pc, model_pc);
                if (known[instr_pc[`MEM_INDEX_BITS+1:2]]) begin
                    check_word("instr", instr, expected_instr(instr_pc));
                end
                model_pc = model_pc + 32'd4;
            end
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run stopped at the %0d cycle limit before the tests ended", LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int         e0;
        int         gap;
        int         n;
        logic       st;
        addr_t      a;
        addr_t      held;
        word_t      d;
        word_t      q;
        redirect    = 1'b0;
        redirect_pc = '0;
        jalr        = 1'b0;
        jalr_pc     = '0;
        md_start    = 1'b0;
        md_is_div   = 1'b0;
        md_finish   = 1'b0;
        lsu_req     = 1'b0;
        lsu_we      = 1'b0;
        lsu_addr    = '0;
        lsu_wdata   = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            known[i] = 1'b0;
        end

        e0 = errors;
        do begin
            @(negedge clk);
            if (!rst_n && (instr_valid !== 1'b0 || lsu_done !== 1'b0)) begin
                report_error("instr_valid or lsu_done high during reset");
            end
        end while (!rst_n);
        check_addr("pc", pc, `RESET_PC);
        check_status("md_status", md_status, MD_IDLE);
        test_done(1, "reset state", e0);

        e0 = errors;
        for (int i = 0; i < N_STORE; i++) begin
            a = BASE + addr_t'(4 * i);
            d = lfsr_bits(32);
            lsu_access(1'b1, a, d, q);
            lsu_access(1'b0, a, '0, q);
            check_word("lsu_rdata", q, expected_instr(a));
        end
        test_done(2, "store then load", e0);

        e0 = errors;
        redirect_to(BASE);
        wait_instr(N_RUN);
        test_done(3, "redirect and sequential fetch", e0);

        e0 = errors;
        jalr_to(BASE + 32'h20);
        wait_instr(1);
        check_addr("instr_pc", instr_pc, BASE + 32'h20);
        check_word("instr", instr, expected_instr(BASE + 32'h20));
        wait_instr(3);
        test_done(4, "jalr target", e0);

        e0 = errors;
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            #1;
            md_start  = 1'b1;
            md_is_div = (k == 1);  // multiply first, then divide
            repeat (3) @(posedge clk);  // fetch in flight retires
            @(negedge clk);
            held = pc;
            repeat (8) begin
                if (instr_valid) begin
                    report_error("instruction delivered during a mul/div hold");
                end
                check_addr("pc", pc, held);
                check_status("md_status", md_status, MD_BUSY);
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            md_finish = 1'b1;
            @(posedge clk);
            #1;
            md_start  = 1'b0;
            md_finish = 1'b0;
            @(negedge clk);
            check_status("md_status", md_status, MD_BUSY);
            n = 0;
            while (md_status !== MD_IDLE && n < 4) begin
                @(negedge clk);
                n++;
            end
            if (md_status !== MD_IDLE) begin
                report_error("md_status did not return to idle after md_finish");
            end
            wait_instr(2);  // fetching resumes
        end
        test_done(5, "mul/div hold", e0);

        e0 = errors;
        redirect_to(BASE);
        for (int k = 0; k < N_MIX; k++) begin
            gap = int'(lfsr_bits(3));
            repeat (gap) @(posedge clk);
            st = (lfsr_bits(1) != 32'd0);
            a  = BASE + addr_t'(4 * lfsr_bits(5));
            d  = lfsr_bits(32);
            lsu_access(st, a, d, q);
            if (!st) begin
                check_word("lsu_rdata", q, expected_instr(a));
            end
        end
        wait_instr(4);
        test_done(6, "fetch with mixed loads and stores", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/core_types_pkg.sv
common/bus_types_pkg.sv
common/mem_bus_if.sv
fetch/pc_gen.sv
fetch/ifetch.sv
source/lsu_port.sv
source/bus_arbiter.sv
source/sram_port.sv
source/fetch_top.sv
sim/tb_clk_gen.sv
sim/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sim.f --top-module tb_fetch_top -o tb_fetch_top

./obj_dir/tb_fetch_top > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
